//--- flist.f
+incdir+verilog
verilog/bridge_pkg.sv
verilog/axi_req_decode.sv
verilog/i2c_cmd_execute.sv
verilog/axi_resp_result.sv
verilog/axi_i2c_bridge.sv
verif/tb_axi_i2c_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator, runs it and reports pass or fail
# Run from anywhere; paths are taken relative to the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_axi_i2c_bridge \
	-Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The testbench prints the pass line only when every check held
if echo "$output" | grep -qx "Verification passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- verif/bridge_tests.txt
# name op addr wdata nack rbyte resp rdata cmd, one test per line
# op is WR or RD, addr wdata rbyte rdata cmd in hex, cmd none means no I2C command
wr_basic       WR 12345a10 000000c3 0 00 OKAY   00000000 5a10c3
wr_upper_wdata WR 1234a0ff deadbe7e 0 00 OKAY   00000000 a0ff7e
rd_basic       RD 12345a11 00000000 0 9c OKAY   005a119c 5a1100
wr_nack        WR 12340102 00000055 1 00 SLVERR 00000000 010255
rd_nack        RD 12343c04 00000000 1 e1 SLVERR 003c04e1 3c0400
wr_decerr      WR 43210010 000000aa 0 00 DECERR 00000000 none
rd_decerr      RD 12350010 00000000 0 77 DECERR 00000000 none
rd_win_top     RD 1234ffff 00000000 0 01 OKAY   00ffff01 ffff00
wr_win_zero    WR 12340000 00000000 0 00 OKAY   00000000 000000
rd_below_win   RD 12330000 00000000 1 00 DECERR 00000000 none
wr_after_err   WR 12347e3c 12345681 0 00 OKAY   00000000 7e3c81
rd_zero_byte   RD 1234205a 00000000 0 00 OKAY   00205a00 205a00
rd_nack_again  RD 12340a0b ffffffff 1 5f SLVERR 000a0b5f 0a0b00
wr_decerr_hi   WR ffff1234 0000000f 1 00 DECERR 00000000 none
rd_after_dec   RD 1234c0de 00000000 0 a5 OKAY   00c0dea5 c0de00
wr_last        WR 12349999 000000ee 0 00 OKAY   00000000 9999ee

//--- verif/tb_axi_i2c_bridge.sv
// Run from the project root to find verif/bridge_tests.txt; I2C side is modelled on ACLK
`include "bridge_defs.svh"

module tb_axi_i2c_bridge
	import bridge_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_TESTS       = 64;
	localparam int MAX_I2C_DELAY   = 12;
	localparam int MAX_READY_DELAY = 5;
	localparam int ACCEPT_LIMIT    = 8;
	localparam int RESP_LIMIT      = MAX_I2C_DELAY + 20;
	localparam logic [31:0] SEED   = 32'd94589;

	logic                          ACLK;
	logic                          SYN_RESET;
	logic                          AWVALID;
	logic [`BRIDGE_ADDR_WIDTH-1:0] AWADDR;
	logic                          AWREADY;
	logic                          WVALID;
	logic [`BRIDGE_DATA_WIDTH-1:0] WDATA;
	logic                          WREADY;
	logic                          BVALID;
	axi_resp_e                     BRESP;
	logic                          BREADY;
	logic                          ARVALID;
	logic [`BRIDGE_ADDR_WIDTH-1:0] ARADDR;
	logic                          ARREADY;
	logic                          RVALID;
	logic [`BRIDGE_DATA_WIDTH-1:0] RDATA;
	axi_resp_e                     RRESP;
	logic                          RREADY;
	logic [`BRIDGE_CMD_WIDTH-1:0]  i2c_cmd;
	logic                          i2c_cmd_read;
	logic                          i2c_cmd_toggle;
	logic                          i2c_done_toggle;
	logic                          i2c_nack;
	logic [`BRIDGE_BYTE_WIDTH-1:0] i2c_rdata;

	// Test table, one entry per data file line
	string                         t_name [MAX_TESTS];
	bridge_op_e                    t_op [MAX_TESTS];
	logic [`BRIDGE_ADDR_WIDTH-1:0] t_addr [MAX_TESTS];
	logic [`BRIDGE_DATA_WIDTH-1:0] t_wdata [MAX_TESTS];
	logic                          t_nack [MAX_TESTS];
	logic [`BRIDGE_BYTE_WIDTH-1:0] t_rbyte [MAX_TESTS];
	axi_resp_e                     t_resp [MAX_TESTS];
	logic [`BRIDGE_DATA_WIDTH-1:0] t_rdata [MAX_TESTS];
	logic                          t_has_cmd [MAX_TESTS];
	logic [`BRIDGE_CMD_WIDTH-1:0]  t_cmd [MAX_TESTS];
	int                            t_toggles_before [MAX_TESTS];

	int n_tests;
	int cycle_limit;
	int cycle_count;
	int active_idx;
	int toggle_count;
	int value_errors;
	int protocol_errors;
	logic tests_loaded;
	logic pre_driven;
	logic [31:0] ready_rng;
	// Last command as the I2C model saw it
	logic [`BRIDGE_CMD_WIDTH-1:0] seen_cmd;
	logic seen_read;

	axi_i2c_bridge i_dut (
		.ACLK            (ACLK),
		.SYN_RESET       (SYN_RESET),
		.AWVALID         (AWVALID),
		.AWADDR          (AWADDR),
		.AWREADY         (AWREADY),
		.WVALID          (WVALID),
		.WDATA           (WDATA),
		.WREADY          (WREADY),
		.BVALID          (BVALID),
		.BRESP           (BRESP),
		.BREADY          (BREADY),
		.ARVALID         (ARVALID),
		.ARADDR          (ARADDR),
		.ARREADY         (ARREADY),
		.RVALID          (RVALID),
		.RDATA           (RDATA),
		.RRESP           (RRESP),
		.RREADY          (RREADY),
		.i2c_cmd         (i2c_cmd),
		.i2c_cmd_read    (i2c_cmd_read),
		.i2c_cmd_toggle  (i2c_cmd_toggle),
		.i2c_done_toggle (i2c_done_toggle),
		.i2c_nack        (i2c_nack),
		.i2c_rdata       (i2c_rdata)
	);

	// 20 ns clock
	initial
	begin
		ACLK = 1'b0;
		forever #10 ACLK = ~ACLK;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Drive point, 2 ns past the rising edge
	task automatic tick();
		@(posedge ACLK);
		#2;
	endtask

	task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
		if (act !== exp)
		begin
			value_errors++;
			$display("** Error %s: response expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_data(input string name, input logic [`BRIDGE_DATA_WIDTH-1:0] exp,
		input logic [`BRIDGE_DATA_WIDTH-1:0] act);
		if (act !== exp)
		begin
			value_errors++;
			$display("** Error %s: RDATA expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_cmd(input string name, input logic [`BRIDGE_CMD_WIDTH-1:0] exp,
		input logic [`BRIDGE_CMD_WIDTH-1:0] act);
		if (act !== exp)
		begin
			value_errors++;
			$display("** Error %s: I2C command expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			value_errors++;
			$display("** Error %s: I2C read flag expected %0b, actual %0b", name, exp, act);
		end
	endtask

	////////////////////
	// Test file
	////////////////////

	task automatic load_tests(output logic ok);
		int fd;
		int got;
		int nack_v;
		logic bad;
		logic [8*160-1:0] line_raw;
		logic [8*32-1:0] name_raw;
		logic [8*8-1:0] op_raw;
		logic [8*8-1:0] resp_raw;
		logic [8*8-1:0] cmd_raw;
		logic [31:0] addr_v;
		logic [31:0] wdata_v;
		logic [31:0] rbyte_v;
		logic [31:0] rdata_v;
		logic [31:0] cmd_v;
		ok = 1'b0;
		bad = 1'b0;
		n_tests = 0;
		fd = $fopen("verif/bridge_tests.txt", "r");
		if (fd == 0)
			$display("Cannot open verif/bridge_tests.txt");
		else
		begin
			while (!$feof(fd) && n_tests < MAX_TESTS)
			begin
				line_raw = '0;
				got = $fgets(line_raw, fd);
				// Comment and blank lines never give all nine fields
				if (got > 0)
					got = $sscanf(line_raw, "%s %s %h %h %d %h %s %h %s", name_raw, op_raw,
						addr_v, wdata_v, nack_v, rbyte_v, resp_raw, rdata_v, cmd_raw);
				if (got == 9)
				begin
					t_name[n_tests]    = string'(name_raw);
					t_op[n_tests]      = (string'(op_raw) == "RD") ? OP_READ : OP_WRITE;
					t_addr[n_tests]    = addr_v;
					t_wdata[n_tests]   = wdata_v;
					t_nack[n_tests]    = (nack_v != 0);
					t_rbyte[n_tests]   = rbyte_v[`BRIDGE_BYTE_WIDTH-1:0];
					t_rdata[n_tests]   = rdata_v;
					t_has_cmd[n_tests] = (string'(cmd_raw) != "none");
					t_resp[n_tests]    = OKAY;
					if (string'(resp_raw) == "SLVERR")
						t_resp[n_tests] = SLVERR;
					else if (string'(resp_raw) == "DECERR")
						t_resp[n_tests] = DECERR;
					// Unknown names fall back to OKAY and are caught here
					if (t_resp[n_tests].name() != string'(resp_raw))
					begin
						bad = 1'b1;
						$display("Unknown response name in test %s", t_name[n_tests]);
					end
					cmd_v = '0;
					if (t_has_cmd[n_tests])
						got = $sscanf(cmd_raw, "%h", cmd_v);
					t_cmd[n_tests] = cmd_v[`BRIDGE_CMD_WIDTH-1:0];
					n_tests++;
				end
			end
			$fclose(fd);
			if (n_tests == 0)
				$display("No tests found in verif/bridge_tests.txt");
			ok = (n_tests > 0) && !bad;
		end
	endtask

	////////////////////
	// AXI master
	////////////////////

	task automatic drive_request(input int i);
		t_toggles_before[i] = toggle_count;
		active_idx = i;
		if (t_op[i] == OP_WRITE)
		begin
			AWADDR  = t_addr[i];
			WDATA   = t_wdata[i];
			AWVALID = 1'b1;
			WVALID  = 1'b1;
		end
		else
		begin
			ARADDR  = t_addr[i];
			ARVALID = 1'b1;
		end
	endtask

	// Ready seen at the drive point means the handshake happens on the next edge
	task automatic accept_request(input int i, output logic ok);
		logic seen;
		seen = 1'b0;
		for (int k = 0; k < ACCEPT_LIMIT && !seen; k++)
		begin
			tick();
			if (t_op[i] == OP_WRITE)
			begin
				if (AWREADY != WREADY)
				begin
					protocol_errors++;
					$display("AWREADY and WREADY differ in test %s", t_name[i]);
				end
				seen = AWREADY && WREADY;
			end
			else
				seen = ARREADY;
		end
		if (!seen)
		begin
			protocol_errors++;
			$display("Request of test %s was never accepted", t_name[i]);
		end
		tick();
		AWVALID = 1'b0;
		WVALID  = 1'b0;
		ARVALID = 1'b0;
		if (seen && (AWREADY || WREADY || ARREADY))
		begin
			protocol_errors++;
			$display("Ready stayed high longer than one cycle in test %s", t_name[i]);
		end
		ok = seen;
	endtask

	task automatic finish_response(input int i);
		logic found;
		logic is_rd;
		int hold;
		axi_resp_e snap_resp;
		logic [`BRIDGE_DATA_WIDTH-1:0] snap_data;
		is_rd = (t_op[i] == OP_READ);
		found = 1'b0;
		for (int k = 0; k < RESP_LIMIT && !found; k++)
		begin
			tick();
			found = is_rd ? RVALID : BVALID;
		end
		if (!found)
		begin
			protocol_errors++;
			$display("No %s response came for test %s", t_op[i].name(), t_name[i]);
		end
		else
		begin
			snap_resp = is_rd ? RRESP : BRESP;
			snap_data = RDATA;
			ready_rng = xorshift32(ready_rng);
			hold = ready_rng % (MAX_READY_DELAY + 1);
			// Next request waits while this response is held back
			if (i + 1 < n_tests)
			begin
				drive_request(i + 1);
				pre_driven = 1'b1;
			end
			for (int k = 0; k <= hold; k++)
			begin
				if (k > 0)
					tick();
				if (!(is_rd ? RVALID : BVALID) || (is_rd ?
					(RRESP !== snap_resp || RDATA !== snap_data) : (BRESP !== snap_resp)))
				begin
					protocol_errors++;
					$display("Response of test %s dropped or changed before ready", t_name[i]);
				end
				if (AWREADY || WREADY || ARREADY)
				begin
					protocol_errors++;
					$display("Next request accepted before response of test %s", t_name[i]);
				end
			end
			if (is_rd)
				RREADY = 1'b1;
			else
				BREADY = 1'b1;
			tick();
			BREADY = 1'b0;
			RREADY = 1'b0;
			if (BVALID || RVALID)
			begin
				protocol_errors++;
				$display("Valid still high after the handshake of test %s", t_name[i]);
			end
			check_resp(t_name[i], t_resp[i], snap_resp);
			if (is_rd)
				check_data(t_name[i], t_rdata[i], snap_data);
			if (t_has_cmd[i])
			begin
				if (toggle_count - t_toggles_before[i] != 1)
				begin
					protocol_errors++;
					$display("Test %s expected one command toggle, saw %0d", t_name[i],
						toggle_count - t_toggles_before[i]);
				end
				check_cmd(t_name[i], t_cmd[i], seen_cmd);
				check_flag(t_name[i], is_rd, seen_read);
			end
			else if (toggle_count != t_toggles_before[i])
			begin
				protocol_errors++;
				$display("I2C command issued for out-of-window test %s", t_name[i]);
			end
		end
	endtask

	task automatic run_test(input int i);
		logic ok;
		if (!pre_driven)
			drive_request(i);
		pre_driven = 1'b0;
		accept_request(i, ok);
		if (ok)
			finish_response(i);
	endtask

	////////////////////
	// I2C side model
	////////////////////

	// Answers each command toggle after a random delay, data set one cycle ahead of done
	initial
	begin
		int delay;
		logic [31:0] rng;
		i2c_done_toggle = 1'b0;
		i2c_nack        = 1'b0;
		i2c_rdata       = '0;
		toggle_count    = 0;
		seen_cmd        = '0;
		seen_read       = 1'b0;
		rng             = SEED;
		wait (SYN_RESET === 1'b1);
		forever
		begin
			@(i2c_cmd_toggle);
			// Command and flag settle in the same edge as the toggle
			#1;
			toggle_count++;
			seen_cmd  = i2c_cmd;
			seen_read = i2c_cmd_read;
			rng = xorshift32(rng);
			delay = rng % MAX_I2C_DELAY + 1;
			repeat (delay) @(posedge ACLK);
			#2;
			i2c_nack  = t_nack[active_idx];
			i2c_rdata = t_rbyte[active_idx];
			tick();
			i2c_done_toggle = ~i2c_done_toggle;
		end
	end

	////////////////////
	// Run control
	////////////////////

	initial
	begin
		cycle_count = 0;
		wait (tests_loaded);
		while (cycle_count < cycle_limit)
		begin
			@(posedge ACLK);
			cycle_count++;
		end
		$display("Run stopped by timeout after %0d cycles", cycle_count);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		logic ok;
		SYN_RESET       = 1'b0;
		AWVALID         = 1'b0;
		AWADDR          = '0;
		WVALID          = 1'b0;
		WDATA           = '0;
		ARVALID         = 1'b0;
		ARADDR          = '0;
		BREADY          = 1'b0;
		RREADY          = 1'b0;
		value_errors    = 0;
		protocol_errors = 0;
		active_idx      = 0;
		pre_driven      = 1'b0;
		tests_loaded    = 1'b0;
		ready_rng       = SEED;
		load_tests(ok);
		if (!ok)
		begin
			$display("Verification failed");
			$finish;
		end
		else
		begin
			// Worst case per test plus margin
			cycle_limit = n_tests * (MAX_I2C_DELAY + MAX_READY_DELAY + 20);
			tests_loaded = 1'b1;
			repeat (2) @(posedge ACLK);
			#2;
			SYN_RESET = 1'b1;
			tick();
			if (AWREADY || WREADY || ARREADY || BVALID || RVALID || i2c_cmd_toggle)
			begin
				protocol_errors++;
				$display("Ready, valid or command toggle not low after reset");
			end
			for (int i = 0; i < n_tests; i++)
				run_test(i);
			$display("Errors: %0d value, %0d protocol, %0d tests run", value_errors,
				protocol_errors, n_tests);
			if (value_errors + protocol_errors == 0)
				$display("Verification passed");
			else
				$display("Verification failed");
			$finish;
		end
	end

endmodule

//--- verilog/axi_i2c_bridge.sv
// SYN_RESET must already be synchronous to ACLK; I2C side runs on its own clock behind toggles
`include "bridge_defs.svh"

module axi_i2c_bridge
	import bridge_pkg::*;
(
	input  logic                          ACLK,
	input  logic                          SYN_RESET,
	// AXI4-Lite write
	input  logic                          AWVALID,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0] AWADDR,
	output logic                          AWREADY,
	input  logic                          WVALID,
	input  logic [`BRIDGE_DATA_WIDTH-1:0] WDATA,
	output logic                          WREADY,
	output logic                          BVALID,
	output axi_resp_e                     BRESP,
	input  logic                          BREADY,
	// AXI4-Lite read
	input  logic                          ARVALID,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0] ARADDR,
	output logic                          ARREADY,
	output logic                          RVALID,
	output logic [`BRIDGE_DATA_WIDTH-1:0] RDATA,
	output axi_resp_e                     RRESP,
	input  logic                          RREADY,
	// I2C master side
	output logic [`BRIDGE_CMD_WIDTH-1:0]  i2c_cmd,
	output logic                          i2c_cmd_read,
	output logic                          i2c_cmd_toggle,
	input  logic                          i2c_done_toggle,
	input  logic                          i2c_nack,
	input  logic [`BRIDGE_BYTE_WIDTH-1:0] i2c_rdata
);

	// Decode to execute
	logic                          req_valid;
	bridge_op_e                    req_op;
	logic                          req_hit;
	logic [`BRIDGE_CMD_WIDTH-1:0]  req_cmd;
	// Execute to result
	logic                          res_valid;
	bridge_op_e                    res_op;
	axi_resp_e                     res_resp;
	logic [`BRIDGE_DATA_WIDTH-1:0] res_rdata;
	// Result back to decode
	logic                          done;

	//////////////////////
	// Request stage
	//////////////////////

	axi_req_decode i_decode (
		.ACLK      (ACLK),
		.SYN_RESET (SYN_RESET),
		.AWVALID   (AWVALID),
		.AWADDR    (AWADDR),
		.AWREADY   (AWREADY),
		.WVALID    (WVALID),
		.WDATA     (WDATA),
		.WREADY    (WREADY),
		.ARVALID   (ARVALID),
		.ARADDR    (ARADDR),
		.ARREADY   (ARREADY),
		.req_valid (req_valid),
		.req_op    (req_op),
		.req_hit   (req_hit),
		.req_cmd   (req_cmd),
		.done      (done)
	);

	// Command issue and done toggle crossing
	i2c_cmd_execute i_execute (
		.ACLK            (ACLK),
		.SYN_RESET       (SYN_RESET),
		.req_valid       (req_valid),
		.req_op          (req_op),
		.req_hit         (req_hit),
		.req_cmd         (req_cmd),
		.i2c_cmd         (i2c_cmd),
		.i2c_cmd_read    (i2c_cmd_read),
		.i2c_cmd_toggle  (i2c_cmd_toggle),
		.i2c_done_toggle (i2c_done_toggle),
		.i2c_nack        (i2c_nack),
		.i2c_rdata       (i2c_rdata),
		.res_valid       (res_valid),
		.res_op          (res_op),
		.res_resp        (res_resp),
		.res_rdata       (res_rdata)
	);

	//////////////////////
	// Response stage
	//////////////////////

	axi_resp_result i_result (
		.ACLK      (ACLK),
		.SYN_RESET (SYN_RESET),
		.res_valid (res_valid),
		.res_op    (res_op),
		.res_resp  (res_resp),
		.res_rdata (res_rdata),
		.BVALID    (BVALID),
		.BRESP     (BRESP),
		.BREADY    (BREADY),
		.RVALID    (RVALID),
		.RDATA     (RDATA),
		.RRESP     (RRESP),
		.RREADY    (RREADY),
		.done      (done)
	);

endmodule

//--- verilog/axi_req_decode.sv
// One request at a time; AW and W must both be valid before a write is taken, writes beat reads
`include "bridge_defs.svh"

module axi_req_decode
	import bridge_pkg::*;
(
	input  logic                          ACLK,
	input  logic                          SYN_RESET,
	// Write address and data channels
	input  logic                          AWVALID,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0] AWADDR,
	output logic                          AWREADY,
	input  logic                          WVALID,
	input  logic [`BRIDGE_DATA_WIDTH-1:0] WDATA,
	output logic                          WREADY,
	// Read address channel
	input  logic                          ARVALID,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0] ARADDR,
	output logic                          ARREADY,
	// Request to the execute stage
	output logic                          req_valid,
	output bridge_op_e                    req_op,
	output logic                          req_hit,
	output logic [`BRIDGE_CMD_WIDTH-1:0]  req_cmd,
	// Response handshake finished
	input  logic                          done
);

	decode_state_e state_q;
	decode_state_e state_d;
	bridge_op_e    op_q;
	logic [`BRIDGE_ADDR_WIDTH-1:0] addr_q;
	logic [`BRIDGE_BYTE_WIDTH-1:0] data_q;
	logic wr_pending;
	logic rd_pending;

	// Full write needs both address and data
	assign wr_pending = AWVALID && WVALID;
	assign rd_pending = ARVALID;

	//////////////////////
	// Request FSM
	//////////////////////

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			DEC_IDLE:
			begin
				if (wr_pending || rd_pending)
					state_d = DEC_ACCEPT;
			end
			// Ready pulse lasts exactly this one cycle
			DEC_ACCEPT:
				state_d = DEC_BUSY;
			// Held here until the B or R handshake
			DEC_BUSY:
			begin
				if (done)
					state_d = DEC_IDLE;
			end
			default:
				state_d = DEC_IDLE;
		endcase
	end

	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			state_q <= DEC_IDLE;
			op_q    <= OP_WRITE;
		end
		else
		begin
			state_q <= state_d;
			// Direction picked when leaving idle, write first
			if (state_q == DEC_IDLE)
				op_q <= wr_pending ? OP_WRITE : OP_READ;
		end
	end

	// Address and data sampled as the request is seen
	always_ff @(posedge ACLK)
	begin
		if (state_q == DEC_IDLE)
		begin
			if (wr_pending)
			begin
				addr_q <= AWADDR;
				data_q <= WDATA[`BRIDGE_BYTE_WIDTH-1:0];
			end
			else if (rd_pending)
			begin
				addr_q <= ARADDR;
				// Reads carry no data byte
				data_q <= '0;
			end
		end
	end

	//////////////////////
	// Outputs
	//////////////////////

	// Ready strobes follow the registered direction
	assign AWREADY = (state_q == DEC_ACCEPT) && (op_q == OP_WRITE);
	assign WREADY  = (state_q == DEC_ACCEPT) && (op_q == OP_WRITE);
	assign ARREADY = (state_q == DEC_ACCEPT) && (op_q == OP_READ);

	// Request goes out alongside the ready pulse
	assign req_valid = (state_q == DEC_ACCEPT);
	assign req_op    = op_q;

	// Window check on the upper address half
	assign req_hit = (addr_q[`BRIDGE_ADDR_WIDTH-1:`BRIDGE_ADDR_WIDTH/2] == `BRIDGE_WINDOW);

	// Device byte, register byte, data byte
	assign req_cmd = {addr_q[15:8], addr_q[7:0], data_q};

endmodule

//--- verilog/axi_resp_result.sv
// B or R valid is held with a stable payload until the matching ready; one result at a time
`include "bridge_defs.svh"

module axi_resp_result
	import bridge_pkg::*;
(
	input  logic                          ACLK,
	input  logic                          SYN_RESET,
	// Result from execute
	input  logic                          res_valid,
	input  bridge_op_e                    res_op,
	input  axi_resp_e                     res_resp,
	input  logic [`BRIDGE_DATA_WIDTH-1:0] res_rdata,
	// Write response channel
	output logic                          BVALID,
	output axi_resp_e                     BRESP,
	input  logic                          BREADY,
	// Read data channel
	output logic                          RVALID,
	output logic [`BRIDGE_DATA_WIDTH-1:0] RDATA,
	output axi_resp_e                     RRESP,
	input  logic                          RREADY,
	// Handshake seen, decode may take the next request
	output logic                          done
);

	result_state_e state_q;

	//////////////////////
	// Channel FSM
	//////////////////////

	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
			state_q <= RES_IDLE;
		else
		begin
			case (state_q)
				RES_IDLE:
				begin
					// Steer by direction
					if (res_valid)
						state_q <= (res_op == OP_READ) ? RES_RVALID : RES_BVALID;
				end
				RES_BVALID:
				begin
					if (BREADY)
						state_q <= RES_IDLE;
				end
				RES_RVALID:
				begin
					if (RREADY)
						state_q <= RES_IDLE;
				end
				default:
					state_q <= RES_IDLE;
			endcase
		end
	end

	// Payload captured once, kept through back-pressure
	always_ff @(posedge ACLK)
	begin
		if (state_q == RES_IDLE && res_valid)
		begin
			if (res_op == OP_READ)
			begin
				RRESP <= res_resp;
				RDATA <= res_rdata;
			end
			else
				BRESP <= res_resp;
		end
	end

	//////////////////////
	// Outputs
	//////////////////////

	assign BVALID = (state_q == RES_BVALID);
	assign RVALID = (state_q == RES_RVALID);

	// Pulse in the handshake cycle itself
	assign done = (BVALID && BREADY) || (RVALID && RREADY);

endmodule

//--- verilog/bridge_defs.svh
// Widths and window value are fixed for a 32-bit AXI4-Lite bus; the window is the upper half only
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

//////////////////////
// AXI4-Lite bus
//////////////////////

// Address and data width of the register bus
`define BRIDGE_ADDR_WIDTH 32
`define BRIDGE_DATA_WIDTH 32

//////////////////////
// I2C command
//////////////////////

// Device byte, register byte, data byte
`define BRIDGE_CMD_WIDTH 24
`define BRIDGE_BYTE_WIDTH 8

// Upper address half that selects the I2C window
`define BRIDGE_WINDOW 16'h1234

// Flops on the done toggle before edge detection
`define BRIDGE_SYNC_STAGES 2

`endif

//--- verilog/bridge_pkg.sv
// Types only; encodings of axi_resp_e follow the AXI BRESP/RRESP field
package bridge_pkg;

	//////////////////////
	// Bus encodings
	//////////////////////

	// AXI response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// Access direction carried through the pipeline
	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} bridge_op_e;

	//////////////////////
	// Stage FSMs
	//////////////////////

	typedef enum logic [1:0] {DEC_IDLE, DEC_ACCEPT, DEC_BUSY} decode_state_e;

	typedef enum logic [1:0] {EX_IDLE, EX_WAIT, EX_DONE} exec_state_e;

	typedef enum logic [1:0] {RES_IDLE, RES_BVALID, RES_RVALID} result_state_e;

endpackage

//--- verilog/i2c_cmd_execute.sv
// I2C side must hold nack and read byte stable before flipping its done toggle; toggle resets low
`include "bridge_defs.svh"

module i2c_cmd_execute
	import bridge_pkg::*;
(
	input  logic                          ACLK,
	input  logic                          SYN_RESET,
	// Request from decode
	input  logic                          req_valid,
	input  bridge_op_e                    req_op,
	input  logic                          req_hit,
	input  logic [`BRIDGE_CMD_WIDTH-1:0]  req_cmd,
	// Command toward the I2C clock domain
	output logic [`BRIDGE_CMD_WIDTH-1:0]  i2c_cmd,
	output logic                          i2c_cmd_read,
	output logic                          i2c_cmd_toggle,
	// Completion from the I2C clock domain
	input  logic                          i2c_done_toggle,
	input  logic                          i2c_nack,
	input  logic [`BRIDGE_BYTE_WIDTH-1:0] i2c_rdata,
	// Result to the response stage
	output logic                          res_valid,
	output bridge_op_e                    res_op,
	output axi_resp_e                     res_resp,
	output logic [`BRIDGE_DATA_WIDTH-1:0] res_rdata
);

	exec_state_e state_q;
	logic [`BRIDGE_SYNC_STAGES-1:0] done_sync;
	logic done_seen;
	logic done_edge;

	//////////////////////
	// Done toggle CDC
	//////////////////////

	// Synchronizer chain, then one flop for edge detect
	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			done_sync <= '0;
			done_seen <= 1'b0;
		end
		else
		begin
			done_sync <= {done_sync[`BRIDGE_SYNC_STAGES-2:0], i2c_done_toggle};
			done_seen <= done_sync[`BRIDGE_SYNC_STAGES-1];
		end
	end

	// Any change of the toggle is one finished command
	assign done_edge = done_sync[`BRIDGE_SYNC_STAGES-1] ^ done_seen;

	//////////////////////
	// Command FSM
	//////////////////////

	always_ff @(posedge ACLK or negedge SYN_RESET)
	begin
		if (!SYN_RESET)
		begin
			state_q        <= EX_IDLE;
			i2c_cmd_toggle <= 1'b0;
		end
		else
		begin
			case (state_q)
				EX_IDLE:
				begin
					if (req_valid && req_hit)
					begin
						// New command announced by a toggle flip
						i2c_cmd_toggle <= ~i2c_cmd_toggle;
						state_q        <= EX_WAIT;
					end
					else if (req_valid)
						state_q <= EX_DONE;
				end
				EX_WAIT:
				begin
					if (done_edge)
						state_q <= EX_DONE;
				end
				// res_valid is high for this single cycle
				EX_DONE:
					state_q <= EX_IDLE;
				default:
					state_q <= EX_IDLE;
			endcase
		end
	end

	// Command held stable for the I2C side until the next request
	always_ff @(posedge ACLK)
	begin
		if (state_q == EX_IDLE && req_valid && req_hit)
		begin
			i2c_cmd      <= req_cmd;
			i2c_cmd_read <= (req_op == OP_READ);
		end
	end

	//////////////////////
	// Result forming
	//////////////////////

	always_ff @(posedge ACLK)
	begin
		if (state_q == EX_IDLE && req_valid)
		begin
			res_op <= req_op;
			// Out of window answered here, no I2C traffic
			if (!req_hit)
			begin
				res_resp  <= DECERR;
				res_rdata <= '0;
			end
		end
		else if (state_q == EX_WAIT && done_edge)
		begin
			res_resp <= i2c_nack ? SLVERR : OKAY;
			// Read data is zero, device, register, read byte
			if (res_op == OP_READ)
				res_rdata <= {{(`BRIDGE_DATA_WIDTH-`BRIDGE_CMD_WIDTH){1'b0}},
					i2c_cmd[`BRIDGE_CMD_WIDTH-1:`BRIDGE_BYTE_WIDTH], i2c_rdata};
			else
				res_rdata <= '0;
		end
	end

	assign res_valid = (state_q == EX_DONE);

endmodule
